/* hdl/riscv_pkg.sv */
package riscv_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] data_t;
  typedef logic [4:0]      reg_adr_t;
  typedef logic [11:0]     csr_adr_t;
  typedef logic [2:0]      acc_size_t;

  // Access size bits, one-hot
  localparam int ACC_BYTE = 0;
  localparam int ACC_HALF = 1;
  localparam int ACC_WORD = 2;

  // Unit select bits
  localparam int NB_UNIT = 3;
  localparam int ALU     = 0;
  localparam int BU      = 1;
  localparam int LSU     = 2;

  // Operation select bits
  localparam int NB_OPERATION = 17;
  localparam int ADD    = 0;
  localparam int SUB    = 1;
  localparam int AND_OP = 2;
  localparam int OR_OP  = 3;
  localparam int XOR_OP = 4;
  localparam int SLT    = 5;
  localparam int SLL    = 6;
  localparam int SRL    = 7;
  localparam int SRA    = 8;
  localparam int BEQ    = 9;
  localparam int BNE    = 10;
  localparam int BLT    = 11;
  localparam int BGE    = 12;
  localparam int JAL    = 13;
  localparam int JALR   = 14;
  localparam int LD     = 15;
  localparam int ST     = 16;

  typedef logic [NB_UNIT-1:0]      unit_t;
  typedef logic [NB_OPERATION-1:0] op_t;

endpackage

/* hdl/trap_pkg.sv */
package trap_pkg;

  typedef enum logic [1:0] {
    USER       = 2'd0,
    SUPERVISOR = 2'd1,
    MACHINE    = 2'd3
  } core_mode_e;

  typedef logic [riscv_pkg::XLEN-1:0] cause_t;

  // Synchronous exception codes
  localparam cause_t CAUSE_PC_MISALIGNED = 'd0;
  localparam cause_t CAUSE_ILLEGAL       = 'd2;
  localparam cause_t CAUSE_LD_MISALIGNED = 'd4;
  localparam cause_t CAUSE_ST_MISALIGNED = 'd6;

  // mstatus bit positions
  localparam int MSTATUS_MIE    = 3;
  localparam int MSTATUS_MPIE   = 7;
  localparam int MSTATUS_MPP_LO = 11;
  localparam int MSTATUS_MPP_HI = 12;

endpackage

/* hdl/exe_if.sv */
// Operands and enables shared by the execute units
interface exe_op_if;
  import riscv_pkg::*;

  data_t     rs1;
  data_t     rs2;
  data_t     imm;
  data_t     pc;
  op_t       operation;
  logic      unsign;
  acc_size_t access_size;
  logic      alu_en;
  logic      bu_en;
  logic      lsu_en;

  modport issue (
    output rs1, rs2, imm, pc, operation, unsign, access_size, alu_en, bu_en, lsu_en
  );

  modport unit (
    input rs1, rs2, imm, pc, operation, unsign, access_size, alu_en, bu_en, lsu_en
  );
endinterface

// Data memory port
interface mem_if;
  import riscv_pkg::*;

  logic      adr_v;
  data_t     adr;
  logic      is_store;
  data_t     store_data;
  acc_size_t access_size;
  data_t     load_data;

  modport master (
    output adr_v, adr, is_store, store_data, access_size,
    input  load_data
  );

  modport slave (
    input  adr_v, adr, is_store, store_data, access_size,
    output load_data
  );
endinterface

/* hdl/alu.sv */
module alu (
  exe_op_if.unit           op,
  output riscv_pkg::data_t res_o
);
  import riscv_pkg::*;

  logic [4:0] shamt;
  logic       lt;
  data_t      slt_res;

  // Shift amount from the low bits of rs2
  assign shamt   = op.rs2[4:0];
  assign lt      = $signed(op.rs1) < $signed(op.rs2);
  assign slt_res = data_t'(lt);

  always_comb begin
    res_o = '0;
    if (op.alu_en) begin
      case (1'b1)
        op.operation[ADD]: begin
          res_o = op.rs1 + op.rs2;
        end
        op.operation[SUB]: begin
          res_o = op.rs1 - op.rs2;
        end
        op.operation[AND_OP]: begin
          res_o = op.rs1 & op.rs2;
        end
        // Also the csrrs source
        op.operation[OR_OP]: begin
          res_o = op.rs1 | op.rs2;
        end
        op.operation[XOR_OP]: begin
          res_o = op.rs1 ^ op.rs2;
        end
        op.operation[SLT]: begin
          res_o = slt_res;
        end
        op.operation[SLL]: begin
          res_o = op.rs1 << shamt;
        end
        op.operation[SRL]: begin
          res_o = op.rs1 >> shamt;
        end
        op.operation[SRA]: begin
          res_o = $signed(op.rs1) >>> shamt;
        end
        default: begin
          res_o = '0;
        end
      endcase
    end
  end

endmodule

/* hdl/bu.sv */
module bu (
  exe_op_if.unit           op,
  output logic             branch_v_o,
  output riscv_pkg::data_t pc_nxt_o,
  output riscv_pkg::data_t link_o,
  output logic             pc_misaligned_o
);
  import riscv_pkg::*;

  logic  eq;
  logic  lt;
  logic  taken;
  data_t jalr_sum;
  data_t pc_rel;

  // --------------------
  // Condition
  // --------------------
  assign eq = (op.rs1 == op.rs2);
  assign lt = op.unsign ? (op.rs1 < op.rs2)
                        : ($signed(op.rs1) < $signed(op.rs2));

  assign taken = (op.operation[BEQ] &  eq)
               | (op.operation[BNE] & ~eq)
               | (op.operation[BLT] &  lt)
               | (op.operation[BGE] & ~lt)
               |  op.operation[JAL]
               |  op.operation[JALR];

  // --------------------
  // Target and link
  // --------------------
  assign jalr_sum = op.rs1 + op.imm;
  assign pc_rel   = op.pc + op.imm;

  // JALR clears bit 0 of the sum
  assign pc_nxt_o = op.operation[JALR] ? {jalr_sum[XLEN-1:1], 1'b0} : pc_rel;
  assign link_o   = op.pc + data_t'(4);

  assign branch_v_o = op.bu_en & taken;

  // No compressed instructions, so bit 1 of a target must be clear
  assign pc_misaligned_o = branch_v_o & pc_nxt_o[1];

endmodule

/* hdl/lsu.sv */
module lsu (
  exe_op_if.unit           op,
  input  riscv_pkg::data_t load_word_i,
  output riscv_pkg::data_t adr_o,
  output riscv_pkg::data_t load_data_o,
  output logic             misaligned_o
);
  import riscv_pkg::*;

  logic [7:0]  byte_sel;
  logic [15:0] half_sel;
  logic        sign_bit;

  assign adr_o = op.rs1 + op.imm;

  assign misaligned_o = op.lsu_en
                      & ((op.access_size[ACC_HALF] & adr_o[0])
                      |  (op.access_size[ACC_WORD] & (|adr_o[1:0])));

  // Byte lane picked by the low address bits
  always_comb begin
    case (adr_o[1:0])
      2'd0:    byte_sel = load_word_i[7:0];
      2'd1:    byte_sel = load_word_i[15:8];
      2'd2:    byte_sel = load_word_i[23:16];
      default: byte_sel = load_word_i[31:24];
    endcase
  end

  assign half_sel = adr_o[1] ? load_word_i[31:16] : load_word_i[15:0];

  // Sign or zero extension
  always_comb begin
    sign_bit    = 1'b0;
    load_data_o = load_word_i;
    if (op.access_size[ACC_BYTE]) begin
      sign_bit    = ~op.unsign & byte_sel[7];
      load_data_o = {{(XLEN-8){sign_bit}}, byte_sel};
    end else if (op.access_size[ACC_HALF]) begin
      sign_bit    = ~op.unsign & half_sel[15];
      load_data_o = {{(XLEN-16){sign_bit}}, half_sel};
    end
  end

endmodule

/* hdl/exe.sv */
module exe (
  input  logic                 clk,
  input  logic                 reset_n,
  // Decoded instruction
  input  riscv_pkg::data_t     pc_i,
  input  logic                 rd_v_i,
  input  riscv_pkg::reg_adr_t  rd_adr_i,
  input  logic                 csr_wbk_i,
  input  riscv_pkg::csr_adr_t  csr_adr_i,
  input  riscv_pkg::data_t     rs1_i,
  input  riscv_pkg::data_t     rs2_i,
  input  riscv_pkg::data_t     imm_i,
  input  riscv_pkg::acc_size_t access_size_i,
  input  logic                 unsign_i,
  input  logic                 csrrw_i,
  input  riscv_pkg::unit_t     unit_i,
  input  riscv_pkg::op_t       operation_i,
  input  logic                 illegal_inst_i,
  input  logic                 mret_i,
  input  logic                 sret_i,
  input  riscv_pkg::data_t     mepc_i,
  input  riscv_pkg::data_t     mtvec_i,
  // Data memory
  mem_if.master                mem,
  // Writeback
  output logic                 wbk_v_o,
  output riscv_pkg::reg_adr_t  wbk_adr_o,
  output riscv_pkg::data_t     wbk_data_o,
  output logic                 csr_wbk_v_o,
  output riscv_pkg::csr_adr_t  csr_adr_o,
  output riscv_pkg::data_t     csr_data_o,
  // Redirect and trap
  output logic                 branch_v_o,
  output riscv_pkg::data_t     pc_data_o,
  output logic                 exception_o,
  output trap_pkg::cause_t     mcause_o,
  output riscv_pkg::data_t     mtval_o,
  output riscv_pkg::data_t     mepc_o,
  output trap_pkg::core_mode_e core_mode_o
);
  import riscv_pkg::*;
  import trap_pkg::*;

  exe_op_if exe_op ();

  data_t      alu_res;
  logic       bu_taken;
  data_t      bu_target;
  data_t      bu_link;
  logic       pc_misaligned;
  data_t      lsu_adr;
  data_t      lsu_data;
  logic       adr_misaligned;
  logic       flush;
  logic       ld_misaligned;
  logic       st_misaligned;
  logic       exception_nxt;
  cause_t     cause_nxt;
  data_t      mtval_nxt;
  data_t      mstatus_nxt;
  logic       mret_v;
  logic       sret_v;
  core_mode_e core_mode_nxt;
  logic       branch_v_nxt;
  data_t      pc_data_nxt;
  data_t      res_nxt;
  data_t      csr_data_nxt;
  logic       branch_dly_q;
  logic       exception_dly_q;

  // --------------------
  // Units
  // --------------------
  assign exe_op.rs1         = rs1_i;
  assign exe_op.rs2         = rs2_i;
  assign exe_op.imm         = imm_i;
  assign exe_op.pc          = pc_i;
  assign exe_op.operation   = operation_i;
  assign exe_op.unsign      = unsign_i;
  assign exe_op.access_size = access_size_i;
  assign exe_op.alu_en      = unit_i[ALU];
  assign exe_op.bu_en       = unit_i[BU];
  assign exe_op.lsu_en      = unit_i[LSU];

  alu u_alu (
    .op    (exe_op),
    .res_o (alu_res)
  );

  bu u_bu (
    .op              (exe_op),
    .branch_v_o      (bu_taken),
    .pc_nxt_o        (bu_target),
    .link_o          (bu_link),
    .pc_misaligned_o (pc_misaligned)
  );

  lsu u_lsu (
    .op           (exe_op),
    .load_word_i  (mem.load_data),
    .adr_o        (lsu_adr),
    .load_data_o  (lsu_data),
    .misaligned_o (adr_misaligned)
  );

  // --------------------
  // Squash and traps
  // --------------------
  // Two instructions already in flight behind a redirect
  assign flush = branch_v_o | branch_dly_q | exception_o | exception_dly_q;

  assign ld_misaligned = adr_misaligned & ~operation_i[ST];
  assign st_misaligned = adr_misaligned &  operation_i[ST];
  assign exception_nxt = (pc_misaligned | illegal_inst_i | adr_misaligned) & ~flush;

  always_comb begin
    cause_nxt = '0;
    mtval_nxt = '0;
    if (pc_misaligned) begin
      cause_nxt = CAUSE_PC_MISALIGNED;
      mtval_nxt = bu_target;
    end else if (illegal_inst_i) begin
      cause_nxt = CAUSE_ILLEGAL;
    end else if (ld_misaligned) begin
      cause_nxt = CAUSE_LD_MISALIGNED;
      mtval_nxt = lsu_adr;
    end else if (st_misaligned) begin
      cause_nxt = CAUSE_ST_MISALIGNED;
      mtval_nxt = lsu_adr;
    end
  end

  // mstatus after mret, from the old value on rs2
  always_comb begin
    mstatus_nxt                                = rs2_i;
    mstatus_nxt[MSTATUS_MIE]                   = rs2_i[MSTATUS_MPIE];
    mstatus_nxt[MSTATUS_MPIE]                  = 1'b1;
    mstatus_nxt[MSTATUS_MPP_HI:MSTATUS_MPP_LO] = MACHINE;
  end

  assign mret_v = mret_i & ~flush & ~exception_nxt;
  assign sret_v = sret_i & ~flush & ~exception_nxt;

  always_comb begin
    core_mode_nxt = core_mode_o;
    if (exception_nxt) begin
      core_mode_nxt = MACHINE;
    end else if (mret_v) begin
      core_mode_nxt = core_mode_e'(rs2_i[MSTATUS_MPP_HI:MSTATUS_MPP_LO]);
    end else if (sret_v) begin
      core_mode_nxt = SUPERVISOR;
    end
  end

  // --------------------
  // Redirect and results
  // --------------------
  assign branch_v_nxt = (bu_taken | mret_i | sret_i) & ~flush & ~exception_nxt;

  // sret returns through the branch target path
  assign pc_data_nxt = exception_nxt ? mtvec_i :
                       mret_i        ? mepc_i  : bu_target;

  always_comb begin
    if (csr_wbk_i) begin
      res_nxt = rs2_i;
    end else if (exe_op.bu_en) begin
      res_nxt = bu_link;
    end else if (exe_op.lsu_en) begin
      res_nxt = lsu_data;
    end else begin
      res_nxt = alu_res;
    end
  end

  assign csr_data_nxt = mret_i  ? mstatus_nxt :
                        csrrw_i ? rs1_i       : alu_res;

  // Memory access dropped on squash or fault
  assign mem.adr_v       = exe_op.lsu_en & ~flush & ~exception_nxt;
  assign mem.adr         = lsu_adr;
  assign mem.is_store    = exe_op.lsu_en & operation_i[ST];
  assign mem.store_data  = rs2_i;
  assign mem.access_size = access_size_i;

  // --------------------
  // Output registers
  // --------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      wbk_v_o         <= 1'b0;
      csr_wbk_v_o     <= 1'b0;
      branch_v_o      <= 1'b0;
      exception_o     <= 1'b0;
      branch_dly_q    <= 1'b0;
      exception_dly_q <= 1'b0;
      core_mode_o     <= MACHINE;
    end else begin
      wbk_v_o         <= rd_v_i & ~flush & ~exception_nxt;
      csr_wbk_v_o     <= csr_wbk_i & ~flush & ~exception_nxt;
      branch_v_o      <= branch_v_nxt;
      exception_o     <= exception_nxt;
      branch_dly_q    <= branch_v_o;
      exception_dly_q <= exception_o;
      core_mode_o     <= core_mode_nxt;
    end
  end

  always_ff @(posedge clk) begin
    wbk_adr_o  <= rd_adr_i;
    wbk_data_o <= res_nxt;
    csr_adr_o  <= csr_adr_i;
    csr_data_o <= csr_data_nxt;
    pc_data_o  <= pc_data_nxt;
    mcause_o   <= cause_nxt;
    mtval_o    <= mtval_nxt;
    mepc_o     <= pc_i;
  end

endmodule

/* hdl/data_ram.sv */
module data_ram (
  input logic  clk,
  mem_if.slave mem
);
  import riscv_pkg::*;

  data_t      ram [0:255];
  logic [7:0] word_idx;
  logic [3:0] byte_en;
  data_t      wdata;

  assign word_idx = mem.adr[9:2];

  // Lane enables and replicated store data
  always_comb begin
    byte_en = 4'b0000;
    wdata   = mem.store_data;
    if (mem.access_size[ACC_BYTE]) begin
      byte_en = 4'b0001 << mem.adr[1:0];
      wdata   = {4{mem.store_data[7:0]}};
    end else if (mem.access_size[ACC_HALF]) begin
      byte_en = mem.adr[1] ? 4'b1100 : 4'b0011;
      wdata   = {2{mem.store_data[15:0]}};
    end else if (mem.access_size[ACC_WORD]) begin
      byte_en = 4'b1111;
    end
  end

  always_ff @(posedge clk) begin
    if (mem.adr_v && mem.is_store) begin
      for (int i = 0; i < 4; i++) begin
        if (byte_en[i]) begin
          ram[word_idx][8*i +: 8] <= wdata[8*i +: 8];
        end
      end
    end
  end

  assign mem.load_data = ram[word_idx];

endmodule

/* hdl/exe_stage_top.sv */
module exe_stage_top (
  input  logic                 clk,
  input  logic                 reset_n,
  input  riscv_pkg::data_t     pc_i,
  input  logic                 rd_v_i,
  input  riscv_pkg::reg_adr_t  rd_adr_i,
  input  logic                 csr_wbk_i,
  input  riscv_pkg::csr_adr_t  csr_adr_i,
  input  riscv_pkg::data_t     rs1_i,
  input  riscv_pkg::data_t     rs2_i,
  input  riscv_pkg::data_t     imm_i,
  input  riscv_pkg::acc_size_t access_size_i,
  input  logic                 unsign_i,
  input  logic                 csrrw_i,
  input  riscv_pkg::unit_t     unit_i,
  input  riscv_pkg::op_t       operation_i,
  input  logic                 illegal_inst_i,
  input  logic                 mret_i,
  input  logic                 sret_i,
  input  riscv_pkg::data_t     mepc_i,
  input  riscv_pkg::data_t     mtvec_i,
  output logic                 wbk_v_o,
  output riscv_pkg::reg_adr_t  wbk_adr_o,
  output riscv_pkg::data_t     wbk_data_o,
  output logic                 csr_wbk_v_o,
  output riscv_pkg::csr_adr_t  csr_adr_o,
  output riscv_pkg::data_t     csr_data_o,
  output logic                 branch_v_o,
  output riscv_pkg::data_t     pc_data_o,
  output logic                 exception_o,
  output trap_pkg::cause_t     mcause_o,
  output riscv_pkg::data_t     mtval_o,
  output riscv_pkg::data_t     mepc_o,
  output trap_pkg::core_mode_e core_mode_o
);

  mem_if mem_bus ();

  // Stage ports share their names with the top ports
  exe u_exe (
    .*,
    .mem (mem_bus.master)
  );

  data_ram u_ram (
    .clk (clk),
    .mem (mem_bus.slave)
  );

endmodule

/* test/exe_chk.sv */
module exe_chk (
  input logic                 clk,
  input logic                 reset_n,
  input logic                 branch_v,
  input logic                 exception,
  input logic                 wbk_v,
  input logic                 csr_wbk_v,
  input logic                 adr_v,
  input trap_pkg::core_mode_e core_mode
);
  timeunit 1ns;
  timeprecision 1ps;
  import trap_pkg::*;

  logic        redirect;
  int unsigned fail_count = 0;

  assign redirect = branch_v | exception;

  // Two squashed instructions follow every redirect
  squash_wbk: assert property (@(posedge clk) disable iff (!reset_n)
    redirect |=> (!wbk_v && !csr_wbk_v) [*2])
    else begin
      $error("Writeback from a squashed instruction");
      fail_count++;
    end

  squash_mem: assert property (@(posedge clk) disable iff (!reset_n)
    redirect |-> !adr_v ##1 !adr_v)
    else begin
      $error("Memory access from a squashed instruction");
      fail_count++;
    end

  trap_mode: assert property (@(posedge clk) disable iff (!reset_n)
    exception |-> core_mode == MACHINE)
    else begin
      $error("Core mode is not machine on a trap");
      fail_count++;
    end

  one_redirect: assert property (@(posedge clk) disable iff (!reset_n)
    !(branch_v && exception))
    else begin
      $error("Branch and exception raised together");
      fail_count++;
    end

endmodule

bind exe exe_chk u_chk (
  .clk       (clk),
  .reset_n   (reset_n),
  .branch_v  (branch_v_o),
  .exception (exception_o),
  .wbk_v     (wbk_v_o),
  .csr_wbk_v (csr_wbk_v_o),
  .adr_v     (mem.adr_v),
  .core_mode (core_mode_o)
);

/* test/tb_exe.sv */
module tb_exe;
  timeunit 1ns;
  timeprecision 1ps;
  import riscv_pkg::*;
  import trap_pkg::*;

  localparam int NF         = 31;
  localparam int NB_IN      = 18;
  localparam int MAX_VEC    = 128;
  localparam int MAX_TOKENS = 8192;

  logic       clk;
  logic       reset_n;
  data_t      pc_i;
  logic       rd_v_i;
  reg_adr_t   rd_adr_i;
  logic       csr_wbk_i;
  csr_adr_t   csr_adr_i;
  data_t      rs1_i;
  data_t      rs2_i;
  data_t      imm_i;
  acc_size_t  access_size_i;
  logic       unsign_i;
  logic       csrrw_i;
  unit_t      unit_i;
  op_t        operation_i;
  logic       illegal_inst_i;
  logic       mret_i;
  logic       sret_i;
  data_t      mepc_i;
  data_t      mtvec_i;
  logic       wbk_v_o;
  reg_adr_t   wbk_adr_o;
  data_t      wbk_data_o;
  logic       csr_wbk_v_o;
  csr_adr_t   csr_adr_o;
  data_t      csr_data_o;
  logic       branch_v_o;
  data_t      pc_data_o;
  logic       exception_o;
  cause_t     mcause_o;
  data_t      mtval_o;
  data_t      mepc_o;
  core_mode_e core_mode_o;

  logic [31:0] vecs [0:MAX_VEC-1][0:NF-1];
  int          n_vec;
  int          errors;

  exe_stage_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // --------------------
  // Golden vectors
  // --------------------
  task automatic read_vectors();
    int          fd;
    int          guard;
    int          field;
    string       tok;
    string       rest;
    logic [31:0] val;
    fd    = $fopen("test/exe_golden.txt", "r");
    guard = 0;
    field = 0;
    if (fd == 0) begin
      $display("Could not open the golden vector file");
      errors++;
      return;
    end
    while (!$feof(fd) && guard < MAX_TOKENS && n_vec < MAX_VEC) begin
      guard++;
      if ($fscanf(fd, "%s", tok) == 1) begin
        if (tok.len() > 0 && tok[0] == "#") begin
          void'($fgets(rest, fd));
        end else begin
          void'($sscanf(tok, "%h", val));
          vecs[n_vec][field] = val;
          field++;
          if (field == NF) begin
            field = 0;
            n_vec++;
          end
        end
      end
    end
    if (guard >= MAX_TOKENS) begin
      $display("Timed out before the end of the golden vector file");
      errors++;
    end
    if (field != 0) begin
      $display("Golden vector file ends inside a vector");
      errors++;
    end
    $fclose(fd);
  endtask

  task automatic idle_inputs();
    {pc_i, rd_v_i, rd_adr_i, csr_wbk_i, csr_adr_i} = '0;
    {rs1_i, rs2_i, imm_i, access_size_i, unsign_i, csrrw_i} = '0;
    {unit_i, operation_i, illegal_inst_i, mret_i, sret_i} = '0;
    mepc_i  = '0;
    mtvec_i = '0;
  endtask

  task automatic apply_vector(input int k);
    pc_i           = vecs[k][0];
    rd_v_i         = vecs[k][1][0];
    rd_adr_i       = vecs[k][2][4:0];
    csr_wbk_i      = vecs[k][3][0];
    csr_adr_i      = vecs[k][4][11:0];
    rs1_i          = vecs[k][5];
    rs2_i          = vecs[k][6];
    imm_i          = vecs[k][7];
    access_size_i  = vecs[k][8][2:0];
    unsign_i       = vecs[k][9][0];
    csrrw_i        = vecs[k][10][0];
    unit_i         = vecs[k][11][2:0];
    operation_i    = vecs[k][12][16:0];
    illegal_inst_i = vecs[k][13][0];
    mret_i         = vecs[k][14][0];
    sret_i         = vecs[k][15][0];
    mepc_i         = vecs[k][16];
    mtvec_i        = vecs[k][17];
  endtask

  // --------------------
  // Comparison
  // --------------------
  task automatic check_field(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // Outputs are only compared where their valid bit is expected high
  task automatic check_outputs(input int k);
    logic [31:0] e [0:12];
    for (int i = 0; i < 13; i++) begin
      e[i] = vecs[k][NB_IN+i];
    end
    check_field("wbk_v", 32'(wbk_v_o), e[0]);
    if (e[0][0]) begin
      check_field("wbk_adr", 32'(wbk_adr_o), e[1]);
      check_field("wbk_data", wbk_data_o, e[2]);
    end
    check_field("csr_wbk_v", 32'(csr_wbk_v_o), e[3]);
    if (e[3][0]) begin
      check_field("csr_adr", 32'(csr_adr_o), e[4]);
      check_field("csr_data", csr_data_o, e[5]);
    end
    check_field("branch_v", 32'(branch_v_o), e[6]);
    check_field("exception", 32'(exception_o), e[8]);
    if (e[6][0] || e[8][0]) begin
      check_field("pc_data", pc_data_o, e[7]);
    end
    if (e[8][0]) begin
      check_field("mcause", mcause_o, e[9]);
      check_field("mtval", mtval_o, e[10]);
      check_field("mepc", mepc_o, e[11]);
    end
    check_field("core_mode", 32'(core_mode_o), e[12]);
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    errors  = 0;
    n_vec   = 0;
    reset_n = 1'b0;
    idle_inputs();
    read_vectors();
    repeat (5) @(posedge clk);
    #2 reset_n = 1'b1;
    #15;
    check_field("wbk_v", 32'(wbk_v_o), 32'd0);
    check_field("csr_wbk_v", 32'(csr_wbk_v_o), 32'd0);
    check_field("branch_v", 32'(branch_v_o), 32'd0);
    check_field("exception", 32'(exception_o), 32'd0);
    check_field("core_mode", 32'(core_mode_o), 32'(MACHINE));
    // Results of vector k are sampled late in the cycle of vector k+1
    for (int k = 0; k <= n_vec; k++) begin
      @(posedge clk);
      #2;
      if (k < n_vec) begin
        apply_vector(k);
      end else begin
        idle_inputs();
      end
      #17;
      if (k > 0) begin
        check_outputs(k - 1);
      end
    end
    $display("Vectors: %0d, errors: %0d, assertion failures: %0d",
             n_vec, errors, i_dut.u_exe.u_chk.fail_count);
    if (errors == 0 && i_dut.u_exe.u_chk.fail_count == 0 && n_vec > 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* test/exe_golden.txt */
# pc rd_v rd csr_wbk csr_adr rs1 rs2 imm acc unsign csrrw unit op ill mret sret mepc mtvec
# then: wbk_v wbk_adr wbk_data csr_v csr_adr csr_data br_v pc_data exc cause mtval mepc mode
0 1 1 0 0 5 7 0 0 0 0 1 1 0 0 0 800 100  1 1 c 0 0 0 0 0 0 0 0 0 3
4 1 2 0 0 3 5 0 0 0 0 1 2 0 0 0 800 100  1 2 fffffffe 0 0 0 0 0 0 0 0 0 3
8 1 3 0 0 f0f0 ff00 0 0 0 0 1 4 0 0 0 800 100  1 3 f000 0 0 0 0 0 0 0 0 0 3
c 1 4 0 0 f0 f 0 0 0 0 1 8 0 0 0 800 100  1 4 ff 0 0 0 0 0 0 0 0 0 3
10 1 5 0 0 ff f 0 0 0 0 1 10 0 0 0 800 100  1 5 f0 0 0 0 0 0 0 0 0 0 3
14 1 6 0 0 ffffffff 1 0 0 0 0 1 20 0 0 0 800 100  1 6 1 0 0 0 0 0 0 0 0 0 3
18 1 7 0 0 3 24 0 0 0 0 1 40 0 0 0 800 100  1 7 30 0 0 0 0 0 0 0 0 0 3
1c 1 8 0 0 80000000 1f 0 0 0 0 1 80 0 0 0 800 100  1 8 1 0 0 0 0 0 0 0 0 0 3
20 1 9 0 0 80000000 4 0 0 0 0 1 100 0 0 0 800 100  1 9 f8000000 0 0 0 0 0 0 0 0 0 3
24 1 1 0 0 5 5 10 0 0 0 2 200 0 0 0 800 100  1 1 28 0 0 0 1 34 0 0 0 0 3
28 1 2 0 0 1 1 0 0 0 0 1 1 0 0 0 800 100  0 0 0 0 0 0 0 0 0 0 0 0 3
2c 1 3 0 0 1 1 0 0 0 0 1 1 0 0 0 800 100  0 0 0 0 0 0 0 0 0 0 0 0 3
30 1 1 0 0 ffffffff 1 20 0 0 0 2 800 0 0 0 800 100  1 1 34 0 0 0 1 50 0 0 0 0 3
34 1 2 0 0 1 1 0 0 0 0 1 1 0 0 0 800 100  0 0 0 0 0 0 0 0 0 0 0 0 3
38 1 3 0 0 1 1 0 0 0 0 1 1 0 0 0 800 100  0 0 0 0 0 0 0 0 0 0 0 0 3
3c 1 1 0 0 ffffffff 1 fffffff8 0 1 0 2 1000 0 0 0 800 100  1 1 40 0 0 0 1 34 0 0 0 0 3
40 1 2 0 0 1 1 0 0 0 0 1 1 0 0 0 800 100  0 0 0 0 0 0 0 0 0 0 0 0 3
44 1 3 0 0 1 1 0 0 0 0 1 1 0 0 0 800 100  0 0 0 0 0 0 0 0 0 0 0 0 3
48 1 1 0 0 0 0 100 0 0 0 2 2000 0 0 0 800 100  1 1 4c 0 0 0 1 148 0 0 0 0 3
4c 1 2 0 0 1 1 0 0 0 0 1 1 0 0 0 800 100  0 0 0 0 0 0 0 0 0 0 0 0 3
50 1 3 0 0 1 1 0 0 0 0 1 1 0 0 0 800 100  0 0 0 0 0 0 0 0 0 0 0 0 3
54 1 1 0 0 201 0 4 0 0 0 2 4000 0 0 0 800 100  1 1 58 0 0 0 1 204 0 0 0 0 3
58 1 2 0 0 1 1 0 0 0 0 1 1 0 0 0 800 100  0 0 0 0 0 0 0 0 0 0 0 0 3
5c 1 3 0 0 1 1 0 0 0 0 1 1 0 0 0 800 100  0 0 0 0 0 0 0 0 0 0 0 0 3
60 0 0 0 0 100 11223344 0 4 0 0 4 10000 0 0 0 800 100  0 0 0 0 0 0 0 0 0 0 0 0 3
64 0 0 0 0 100 aa 1 1 0 0 4 10000 0 0 0 800 100  0 0 0 0 0 0 0 0 0 0 0 0 3
68 0 0 0 0 100 8001 2 2 0 0 4 10000 0 0 0 800 100  0 0 0 0 0 0 0 0 0 0 0 0 3
6c 1 a 0 0 100 0 1 1 0 0 4 8000 0 0 0 800 100  1 a ffffffaa 0 0 0 0 0 0 0 0 0 3
70 1 b 0 0 100 0 1 1 1 0 4 8000 0 0 0 800 100  1 b aa 0 0 0 0 0 0 0 0 0 3
74 1 c 0 0 100 0 2 2 0 0 4 8000 0 0 0 800 100  1 c ffff8001 0 0 0 0 0 0 0 0 0 3
78 1 d 0 0 100 0 2 2 1 0 4 8000 0 0 0 800 100  1 d 8001 0 0 0 0 0 0 0 0 0 3
7c 1 e 0 0 100 0 0 4 0 0 4 8000 0 0 0 800 100  1 e 8001aa44 0 0 0 0 0 0 0 0 0 3
80 1 f 1 300 1234 88 0 0 0 1 0 0 0 0 0 800 100  1 f 88 1 300 1234 0 0 0 0 0 0 3
84 1 10 1 340 f f0 0 0 0 0 1 8 0 0 0 800 100  1 10 f0 1 340 ff 0 0 0 0 0 0 3
88 0 0 1 300 0 80 0 0 0 0 0 0 0 1 0 800 100  0 0 0 1 300 1888 1 800 0 0 0 0 0
8c 1 1 0 0 0 0 0 0 0 0 0 0 1 0 0 800 100  0 0 0 0 0 0 0 0 0 0 0 0 0
90 1 1 0 0 1 1 0 0 0 0 1 1 0 0 0 800 100  0 0 0 0 0 0 0 0 0 0 0 0 0
94 0 0 0 0 0 0 0 0 0 0 0 0 0 0 1 800 100  0 0 0 0 0 0 1 94 0 0 0 0 1
98 1 2 0 0 1 1 0 0 0 0 1 1 0 0 0 800 100  0 0 0 0 0 0 0 0 0 0 0 0 1
9c 1 3 0 0 1 1 0 0 0 0 1 1 0 0 0 800 100  0 0 0 0 0 0 0 0 0 0 0 0 1
a0 1 1 0 0 0 0 0 0 0 0 1 1 1 0 0 800 100  0 0 0 0 0 0 0 100 1 2 0 a0 3
a4 1 2 0 0 1 1 0 0 0 0 1 1 0 0 0 800 100  0 0 0 0 0 0 0 0 0 0 0 0 3
a8 1 3 0 0 1 1 0 0 0 0 1 1 0 0 0 800 100  0 0 0 0 0 0 0 0 0 0 0 0 3
ac 1 2 0 0 100 0 2 4 0 0 4 8000 0 0 0 800 100  0 0 0 0 0 0 0 100 1 4 102 ac 3
b0 1 2 0 0 1 1 0 0 0 0 1 1 0 0 0 800 100  0 0 0 0 0 0 0 0 0 0 0 0 3
b4 1 3 0 0 1 1 0 0 0 0 1 1 0 0 0 800 100  0 0 0 0 0 0 0 0 0 0 0 0 3
b8 0 0 0 0 100 ffff 3 2 0 0 4 10000 0 0 0 800 100  0 0 0 0 0 0 0 100 1 6 103 b8 3
bc 1 2 0 0 1 1 0 0 0 0 1 1 0 0 0 800 100  0 0 0 0 0 0 0 0 0 0 0 0 3
c0 1 3 0 0 1 1 0 0 0 0 1 1 0 0 0 800 100  0 0 0 0 0 0 0 0 0 0 0 0 3
c4 1 1 0 0 0 0 6 0 0 0 2 2000 1 0 0 800 100  0 0 0 0 0 0 0 100 1 0 ca c4 3
c8 1 2 0 0 1 1 0 0 0 0 1 1 0 0 0 800 100  0 0 0 0 0 0 0 0 0 0 0 0 3
cc 1 3 0 0 1 1 0 0 0 0 1 1 0 0 0 800 100  0 0 0 0 0 0 0 0 0 0 0 0 3
d0 1 3 0 0 100 0 0 4 0 0 4 8000 0 0 0 800 100  1 3 8001aa44 0 0 0 0 0 0 0 0 0 3

/* filelist.f */
hdl/riscv_pkg.sv
hdl/trap_pkg.sv
hdl/exe_if.sv
hdl/alu.sv
hdl/bu.sv
hdl/lsu.sv
hdl/exe.sv
hdl/data_ram.sv
hdl/exe_stage_top.sv
test/exe_chk.sv
test/tb_exe.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_exe
FILELIST = filelist.f
OBJ_DIR  = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf $(OBJ_DIR)
